/* tb.f */
source/cemf_pkg.sv
source/cemf_edge_counter.sv
source/tdc_event_sync.sv
source/step_sequencer.sv
source/cemf_sequencer_top.sv
dv/tb_checker.sv
dv/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_top.sv */
module tb_top;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned SYNC_STAGES = 2;
	localparam logic [cemf_pkg::ADDR_W-1:0] ADDR_BASE = 16'd8;
	localparam int NUM_FRAMES = 3;
	localparam int MAX_STEPS  = 6;

	logic                        clk;
	logic                        rst_n;
	logic                        run_i;
	logic [cemf_pkg::STEP_W-1:0] steps_i;
	logic                        cemf_i;
	logic                        trigger_i;
	logic                        intb_a_i;
	logic                        intb_b_i;
	logic                        end_read_i;
	logic [cemf_pkg::DATA_W-1:0] prdata_i;
	logic                        pready_i;
	logic                        psel_o;
	logic                        penable_o;
	logic [cemf_pkg::ADDR_W-1:0] paddr_o;
	logic                        start_op_a_o;
	logic                        start_op_b_o;
	logic                        start_read_a_o;
	logic                        start_read_b_o;
	logic                        start_gen_o;
	logic                        stop_gen_o;
	logic                        frame_o;
	logic                        step_active_o;
	logic                        en_fe_o;
	logic                        stop_o;
	int                          err_cnt;

	logic [31:0]          lcg_state = 32'h86b595b9;
	cemf_pkg::step_word_t mem [NUM_FRAMES][MAX_STEPS];	// Step words per frame
	int                   frame_steps [NUM_FRAMES];
	int                   frame_idx;	// Frame the APB model serves
	int                   apb_wait;
	logic                 last_bank_b;	// Bank of the latest start_op
	int unsigned          limit;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Uniform-ish value in lo..hi from the upper LCG bits
	function automatic int rand_range(int lo, int hi);
		logic [31:0] r;
		r = lcg_next();
		return lo + int'((r >> 8) % (hi - lo + 1));
	endfunction

	cemf_sequencer_top #(
		.SYNC_STAGES (SYNC_STAGES),
		.ADDR_BASE   (ADDR_BASE)
	) i_dut (
		.clk (clk), .rst_n (rst_n), .run_i (run_i), .steps_i (steps_i), .cemf_i (cemf_i),
		.trigger_i (trigger_i), .intb_a_i (intb_a_i), .intb_b_i (intb_b_i),
		.end_read_i (end_read_i), .prdata_i (prdata_i), .pready_i (pready_i),
		.psel_o (psel_o), .penable_o (penable_o), .paddr_o (paddr_o),
		.start_op_a_o (start_op_a_o), .start_op_b_o (start_op_b_o),
		.start_read_a_o (start_read_a_o), .start_read_b_o (start_read_b_o),
		.start_gen_o (start_gen_o), .stop_gen_o (stop_gen_o), .frame_o (frame_o),
		.step_active_o (step_active_o), .en_fe_o (en_fe_o), .stop_o (stop_o)
	);

	tb_checker #(
		.SYNC_STAGES (SYNC_STAGES),
		.ADDR_BASE   (ADDR_BASE)
	) i_checker (
		.clk (clk), .rst_n (rst_n), .run_i (run_i), .steps_i (steps_i), .cemf_i (cemf_i),
		.intb_a_i (intb_a_i), .intb_b_i (intb_b_i), .end_read_i (end_read_i),
		.prdata_i (prdata_i), .pready_i (pready_i), .psel_i (psel_o),
		.penable_i (penable_o), .paddr_i (paddr_o), .start_op_a_i (start_op_a_o),
		.start_op_b_i (start_op_b_o), .start_read_a_i (start_read_a_o),
		.start_read_b_i (start_read_b_o), .start_gen_i (start_gen_o),
		.stop_gen_i (stop_gen_o), .frame_i (frame_o), .step_active_i (step_active_o),
		.en_fe_i (en_fe_o), .stop_i (stop_o),
		.err_cnt_o (err_cnt)
	);

	always #4 clk = ~clk;	// 8 ns period

	// APB memory with 0 to 3 wait cycles
	always @(posedge clk)
	begin
		if (psel_o && penable_o && !pready_i)
		begin
			if (apb_wait == 0)
			begin
				pready_i <= 1'b1;
				if (paddr_o - ADDR_BASE < MAX_STEPS)
					prdata_i <= mem[frame_idx][paddr_o - ADDR_BASE];
				else
					prdata_i <= '0;
			end
			else
				apb_wait <= apb_wait - 1;
		end
		else
		begin
			pready_i <= 1'b0;
			if (psel_o && !penable_o)	// Setup cycle
				apb_wait <= rand_range(0, 3);
		end
	end

	// CEMF wave, random half period
	initial
	begin
		forever
		begin
			repeat (rand_range(6, 12)) @(posedge clk);
			cemf_i <= ~cemf_i;
		end
	end

	// TDC interrupt after each stop_gen rise
	always @(posedge clk)
	begin
		if (start_op_a_o || start_op_b_o)
			last_bank_b <= start_op_b_o;
	end

	initial
	begin
		forever
		begin
			@(posedge clk);
			if (stop_gen_o && !intb_a_i == 1'b0 && !intb_b_i == 1'b0)
			begin
				repeat (rand_range(5, 30)) @(posedge clk);
				if (last_bank_b)
					intb_b_i <= 1'b0;
				else
					intb_a_i <= 1'b0;
				repeat (3) @(posedge clk);
				intb_a_i <= 1'b1;
				intb_b_i <= 1'b1;
				@(negedge stop_gen_o or posedge clk);	// Ride out the rest of stop_gen
				while (stop_gen_o)
					@(posedge clk);
			end
		end
	end

	// Final download answered with end_read after 10 cycles
	initial
	begin
		forever
		begin
			@(posedge clk);
			if ((start_read_a_o || start_read_b_o) && !start_op_a_o && !start_op_b_o)
			begin
				repeat (10) @(posedge clk);
				end_read_i <= 1'b1;
				@(posedge clk);
				end_read_i <= 1'b0;
			end
		end
	end

	initial
	begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		run_i      = 1'b0;
		steps_i    = '0;
		cemf_i     = 1'b0;
		trigger_i  = 1'b1;	// Held high for the whole run
		intb_a_i   = 1'b1;
		intb_b_i   = 1'b1;
		end_read_i = 1'b0;
		prdata_i   = '0;
		pready_i   = 1'b0;
		apb_wait   = 0;
		frame_idx  = 0;
		last_bank_b = 1'b0;
		limit      = 0;

		for (int f = 0; f < NUM_FRAMES; f++)
		begin
			frame_steps[f] = rand_range(1, MAX_STEPS);
			for (int s = 0; s < MAX_STEPS; s++)
			begin
				mem[f][s].delay   = 8'(rand_range(0, 3));
				mem[f][s].cycles  = 8'(rand_range(1, 4));
				mem[f][s].timeout = 16'(rand_range(20, 400));
				if (s < frame_steps[f])
					limit += mem[f][s].timeout + 200;
			end
		end
		limit = limit * 4 + 100 * NUM_FRAMES;

		fork
			begin
				repeat (limit) @(posedge clk);
				$display("Watchdog expired after %0d cycles, run did not finish", limit);
				$display("TESTS FAILED");
				$finish;
			end
		join_none

		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk);

		for (int f = 0; f < NUM_FRAMES; f++)
		begin
			frame_idx = f;
			steps_i <= cemf_pkg::STEP_W'(frame_steps[f]);
			run_i   <= 1'b1;
			@(posedge clk);
			while (!frame_o)
				@(posedge clk);
			run_i <= 1'b0;	// Sampled only in idle
			while (frame_o)
				@(posedge clk);
			repeat (20) @(posedge clk);	// Idle with run_i low
		end

		$display("Checker reported %0d errors", err_cnt);
		if (err_cnt == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* dv/tb_checker.sv */
module tb_checker #(
	parameter int unsigned                 SYNC_STAGES = 2,
	parameter logic [cemf_pkg::ADDR_W-1:0] ADDR_BASE   = 16'd8
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        run_i,
	input  logic [cemf_pkg::STEP_W-1:0] steps_i,
	input  logic                        cemf_i,
	input  logic                        intb_a_i,
	input  logic                        intb_b_i,
	input  logic                        end_read_i,
	input  logic [cemf_pkg::DATA_W-1:0] prdata_i,
	input  logic                        pready_i,
	input  logic                        psel_i,
	input  logic                        penable_i,
	input  logic [cemf_pkg::ADDR_W-1:0] paddr_i,
	input  logic                        start_op_a_i,
	input  logic                        start_op_b_i,
	input  logic                        start_read_a_i,
	input  logic                        start_read_b_i,
	input  logic                        start_gen_i,
	input  logic                        stop_gen_i,
	input  logic                        frame_i,
	input  logic                        step_active_i,
	input  logic                        en_fe_i,
	input  logic                        stop_i,
	output int                          err_cnt_o
);

	timeunit 1ns;
	timeprecision 1ps;

	cemf_pkg::step_word_t word;		// Word of the running step, taken off the bus
	logic        psel_d;
	logic        penable_d;
	logic        pready_d;
	logic        cemf_d;
	logic        sgen_d;
	logic        pgen_d;
	logic        end_read_d;
	logic [cemf_pkg::ADDR_W-1:0] paddr_d;
	int          rd_idx;			// Reads in this frame
	int          ops;				// start_op pulses in this frame
	logic        exp_bank_b;		// Bank of next start_op
	logic        last_b;			// Bank started last
	logic        exp_frame;
	logic        exp_en_fe;
	logic        exp_active;		// Expected step_active_o
	logic        exp_idle;			// Sequencer idle in the model
	logic        final_dl;			// Final download in this cycle
	logic        counting;
	int          win_cnt;			// Raw CEMF rises in the window
	longint      cyc;
	longint      op_cyc;
	logic        irq_low;			// Started bank interrupt seen low
	int          irq_dly;			// Cycles until the DUT has seen the interrupt

	initial
	begin
		err_cnt_o = 0;
		rd_idx = 0;
		ops = 0;
		exp_bank_b = 1'b0;
		last_b = 1'b0;
		exp_frame = 1'b0;
		exp_en_fe = 1'b0;
		exp_active = 1'b0;
		exp_idle = 1'b1;
		final_dl = 1'b0;
		counting = 1'b0;
		win_cnt = 0;
		cyc = 0;
		op_cyc = 0;
		irq_low = 1'b0;
		irq_dly = 0;
		psel_d = 0;
		penable_d = 0;
		pready_d = 0;
		cemf_d = 0;
		sgen_d = 0;
		pgen_d = 0;
		end_read_d = 0;
		paddr_d = '0;
		word = '0;
	end

	task automatic mismatch(string name, longint exp_v, longint act_v);
		err_cnt_o++;
		$display("** Error at %0t: %s expected %0h actual %0h", $time, name, exp_v, act_v);
	endtask

	task automatic failure(string what);
		err_cnt_o++;
		$display("Failure at %0t: %s", $time, what);
	endtask

	// End of a step, by next read or final download
	task automatic step_end_check();
		if (!irq_low)
			failure("step ended before its interrupt");
		if (cyc - op_cyc < longint'(word.timeout))
			mismatch("step length", word.timeout, cyc - op_cyc);
	endtask

	always @(posedge clk)
	begin
		if (rst_n)
		begin
			cyc++;
			final_dl = 1'b0;
			if (end_read_d)
				exp_idle = 1'b1;	// Back in idle the cycle after end_read
			// Synchronizer, fall flag and irq_seen take SYNC_STAGES+2 cycles
			if (irq_dly > 0)
			begin
				irq_dly--;
				if (irq_dly == 0)
					exp_active = 1'b0;
			end

			// APB protocol and addresses
			if (psel_i && !psel_d)
			begin
				if (exp_idle)
					failure("APB read started while the sequencer should be idle");
				if (penable_i)
					mismatch("penable_o", 0, penable_i);
				if (paddr_i != ADDR_BASE + rd_idx)
					mismatch("paddr_o", ADDR_BASE + rd_idx, paddr_i);
				if (ops > 0)
					step_end_check();
				rd_idx++;
				exp_active = 1'b1;	// High from the setup cycle
			end
			if (psel_d && !penable_d && !(psel_i && penable_i))
				failure("setup cycle not followed by access phase");
			if (psel_d && penable_d && !pready_d)
			begin
				if (!(psel_i && penable_i))
					failure("access phase left without pready");
				if (paddr_i != paddr_d)
					mismatch("paddr_o", paddr_d, paddr_i);
			end
			if (psel_i && penable_i && pready_i)
				word = prdata_i;

			// Bank strobes
			if (start_op_a_i || start_op_b_i)
			begin
				if (start_op_a_i == exp_bank_b || start_op_b_i != exp_bank_b)
					mismatch("start_op_b_o", exp_bank_b, start_op_b_i);
				if (start_read_a_i != (ops > 0 && exp_bank_b))
					mismatch("start_read_a_o", ops > 0 && exp_bank_b, start_read_a_i);
				if (start_read_b_i != (ops > 0 && !exp_bank_b))
					mismatch("start_read_b_o", ops > 0 && !exp_bank_b, start_read_b_i);
				ops++;
				last_b     = exp_bank_b;
				exp_bank_b = !exp_bank_b;
				op_cyc     = cyc;
				irq_low    = 1'b0;
				exp_en_fe  = 1'b1;
			end
			else if (start_read_a_i || start_read_b_i)
			begin
				// Final download of the bank started last
				if (start_read_b_i != last_b || start_read_a_i == last_b)
					mismatch("start_read_b_o", last_b, start_read_b_i);
				if (rd_idx != int'(steps_i))
					mismatch("reads per frame", steps_i, rd_idx);
				step_end_check();
				rd_idx   = 0;
				ops      = 0;
				final_dl = 1'b1;
			end
			if ((last_b ? !intb_b_i : !intb_a_i) && !irq_low)
			begin
				irq_low = 1'b1;
				irq_dly = SYNC_STAGES + 2;
			end

			// CEMF window
			if (start_gen_i && stop_gen_i)
				failure("start_gen_o and stop_gen_o overlap");
			if (start_gen_i && !sgen_d)
			begin
				counting = 1'b1;
				win_cnt  = 0;
			end
			else if (counting && cemf_i && !cemf_d)
				win_cnt++;
			if (stop_gen_i && !pgen_d)
			begin
				if (!counting)
					failure("stop_gen_o rose without start_gen_o");
				else if (win_cnt != int'(word.cycles))
					mismatch("CEMF rises in window", word.cycles, win_cnt);
				counting = 1'b0;
			end

			// Frame and stop levels
			if (start_op_a_i || start_op_b_i)
				exp_frame = 1'b1;
			else if (end_read_d)
				exp_frame = 1'b0;
			if (frame_i != exp_frame)
				mismatch("frame_o", exp_frame, frame_i);
			if (en_fe_i != exp_en_fe)
				mismatch("en_fe_o", exp_en_fe, en_fe_i);
			if (final_dl)
				exp_en_fe = 1'b0;	// Low after the final download strobe
			if (step_active_i != exp_active)
				mismatch("step_active_o", exp_active, step_active_i);
			if (stop_i != (exp_idle && !run_i))
				mismatch("stop_o", exp_idle && !run_i, stop_i);
			if (exp_idle && !run_i
				&& (start_op_a_i || start_op_b_i || start_read_a_i || start_read_b_i))
				failure("strobe while idle with run_i low");
			if (exp_idle && run_i)
				exp_idle = 1'b0;	// Read starts next cycle

			psel_d     = psel_i;
			penable_d  = penable_i;
			pready_d   = pready_i;
			paddr_d    = paddr_i;
			cemf_d     = cemf_i;
			sgen_d     = start_gen_i;
			pgen_d     = stop_gen_i;
			end_read_d = end_read_i;
		end
	end

endmodule

/* source/cemf_sequencer_top.sv */
module cemf_sequencer_top #(
	parameter int unsigned                 SYNC_STAGES = 2,		// Depth of both synchronizers
	parameter logic [cemf_pkg::ADDR_W-1:0] ADDR_BASE   = 16'd8	// First step word address
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        run_i,
	input  logic [cemf_pkg::STEP_W-1:0] steps_i,
	input  logic                        cemf_i,
	input  logic                        trigger_i,
	input  logic                        intb_a_i,
	input  logic                        intb_b_i,
	input  logic                        end_read_i,
	input  logic [cemf_pkg::DATA_W-1:0] prdata_i,
	input  logic                        pready_i,
	output logic                        psel_o,
	output logic                        penable_o,
	output logic [cemf_pkg::ADDR_W-1:0] paddr_o,
	output logic                        start_op_a_o,
	output logic                        start_op_b_o,
	output logic                        start_read_a_o,
	output logic                        start_read_b_o,
	output logic                        start_gen_o,
	output logic                        stop_gen_o,
	output logic                        frame_o,
	output logic                        step_active_o,
	output logic                        en_fe_o,
	output logic                        stop_o
);

	// CEMF front end to sequencer
	logic                            cemf_rise;
	logic                            cemf_fall;
	logic [cemf_pkg::CEMF_CNT_W-1:0] cemf_count;
	logic                            cemf_cnt_en;

	// TDC front end to sequencer
	logic trigger_sync;
	logic intb_a_fall;
	logic intb_b_fall;

	cemf_edge_counter #(
		.SYNC_STAGES (SYNC_STAGES)
	) i_cemf_edge_counter (
		.clk      (clk),
		.rst_n    (rst_n),
		.cemf_i   (cemf_i),
		.cnt_en_i (cemf_cnt_en),
		.rise_o   (cemf_rise),
		.fall_o   (cemf_fall),
		.count_o  (cemf_count)
	);

	tdc_event_sync #(
		.SYNC_STAGES (SYNC_STAGES)
	) i_tdc_event_sync (
		.clk           (clk),
		.rst_n         (rst_n),
		.trigger_i     (trigger_i),
		.intb_a_i      (intb_a_i),
		.intb_b_i      (intb_b_i),
		.trigger_o     (trigger_sync),
		.intb_a_fall_o (intb_a_fall),
		.intb_b_fall_o (intb_b_fall)
	);

	step_sequencer #(
		.ADDR_BASE (ADDR_BASE)
	) i_step_sequencer (
		.clk            (clk),
		.rst_n          (rst_n),
		.run_i          (run_i),
		.steps_i        (steps_i),
		.cemf_rise_i    (cemf_rise),
		.cemf_fall_i    (cemf_fall),
		.cemf_count_i   (cemf_count),
		.trigger_i      (trigger_sync),
		.intb_a_fall_i  (intb_a_fall),
		.intb_b_fall_i  (intb_b_fall),
		.end_read_i     (end_read_i),
		.prdata_i       (prdata_i),
		.pready_i       (pready_i),
		.cemf_cnt_en_o  (cemf_cnt_en),
		.psel_o         (psel_o),
		.penable_o      (penable_o),
		.paddr_o        (paddr_o),
		.start_op_a_o   (start_op_a_o),
		.start_op_b_o   (start_op_b_o),
		.start_read_a_o (start_read_a_o),
		.start_read_b_o (start_read_b_o),
		.start_gen_o    (start_gen_o),
		.stop_gen_o     (stop_gen_o),
		.frame_o        (frame_o),
		.step_active_o  (step_active_o),
		.en_fe_o        (en_fe_o),
		.stop_o         (stop_o)
	);

endmodule

/* source/step_sequencer.sv */
module step_sequencer #(
	parameter logic [cemf_pkg::ADDR_W-1:0] ADDR_BASE = 16'd8	// First step word
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            run_i,			// Frame request level
	input  logic [cemf_pkg::STEP_W-1:0]     steps_i,		// Steps per frame, 1 or more
	input  logic                            cemf_rise_i,
	input  logic                            cemf_fall_i,
	input  logic [cemf_pkg::CEMF_CNT_W-1:0] cemf_count_i,	// Rises since enable
	input  logic                            trigger_i,		// Synchronized trigger
	input  logic                            intb_a_fall_i,
	input  logic                            intb_b_fall_i,
	input  logic                            end_read_i,		// Download done pulse
	input  logic [cemf_pkg::DATA_W-1:0]     prdata_i,
	input  logic                            pready_i,
	output logic                            cemf_cnt_en_o,
	output logic                            psel_o,
	output logic                            penable_o,
	output logic [cemf_pkg::ADDR_W-1:0]     paddr_o,
	output logic                            start_op_a_o,
	output logic                            start_op_b_o,
	output logic                            start_read_a_o,
	output logic                            start_read_b_o,
	output logic                            start_gen_o,
	output logic                            stop_gen_o,
	output logic                            frame_o,
	output logic                            step_active_o,
	output logic                            en_fe_o,
	output logic                            stop_o
);

	typedef enum logic [3:0] {
		ST_IDLE,		// Waiting for run_i
		ST_SETUP,		// APB setup cycle
		ST_ACCESS,		// APB access phase
		ST_FIRE,		// start_op and start_read strobes
		ST_START_WAIT,	// Delay in CEMF cycles
		ST_START_GEN,	// start_gen high
		ST_STOP_WAIT,	// Window in CEMF cycles
		ST_STOP_GEN,	// stop_gen high
		ST_END_WAIT,	// Interrupt and timeout
		ST_LAST_READ,	// Download of last bank
		ST_END_READ		// Waiting for end_read_i
	} state_t;

	state_t                          state_q;
	state_t                          state_d;
	logic [cemf_pkg::STEP_W-1:0]     step_idx_q;
	logic [cemf_pkg::ADDR_W-1:0]     addr_q;
	cemf_pkg::step_word_t            word_q;		// Current step word
	logic                            bank_q;		// 0 next start on A, 1 next on B
	logic                            irq_seen_q;	// Interrupt of this step seen
	logic [cemf_pkg::TIMEOUT_W-1:0]  tmo_cnt_q;		// Clocks since start_op
	logic                            frame_q;
	logic                            en_fe_q;

	logic                            in_step;		// Between start_op and step end
	logic                            irq_fall;		// Fall on the bank started last
	logic                            step_done;
	logic                            last_step;
	logic                            first_step;
	logic [cemf_pkg::CEMF_CNT_W-1:0] start_thr;		// Rises before start_gen
	logic [cemf_pkg::CEMF_CNT_W-1:0] stop_thr;		// Rises before stop_gen

	assign in_step    = state_q inside {ST_START_WAIT, ST_START_GEN, ST_STOP_WAIT,
		ST_STOP_GEN, ST_END_WAIT};
	assign irq_fall   = bank_q ? intb_a_fall_i : intb_b_fall_i;	// bank_q already toggled
	assign step_done  = (irq_seen_q || irq_fall) && (tmo_cnt_q >= word_q.timeout);
	assign last_step  = (step_idx_q + 1'b1) == steps_i;
	assign first_step = step_idx_q == '0;
	assign start_thr  = cemf_pkg::CEMF_CNT_W'(word_q.delay);
	assign stop_thr   = start_thr + cemf_pkg::CEMF_CNT_W'(word_q.cycles);

	// Next state
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:
				if (run_i)
					state_d = ST_SETUP;
			ST_SETUP:
				state_d = ST_ACCESS;
			ST_ACCESS:
				if (pready_i)
					state_d = ST_FIRE;
			ST_FIRE:
				state_d = ST_START_WAIT;
			ST_START_WAIT:
				if (cemf_rise_i && cemf_count_i >= start_thr && trigger_i)
					state_d = ST_START_GEN;
			ST_START_GEN:
				if (cemf_fall_i)
					state_d = ST_STOP_WAIT;
			ST_STOP_WAIT:
				if (cemf_rise_i && cemf_count_i >= stop_thr)
					state_d = ST_STOP_GEN;
			ST_STOP_GEN:
				if (cemf_fall_i)
					state_d = ST_END_WAIT;
			ST_END_WAIT:
				if (step_done)
					state_d = last_step ? ST_LAST_READ : ST_SETUP;
			ST_LAST_READ:
				state_d = ST_END_READ;
			ST_END_READ:
				if (end_read_i)
					state_d = ST_IDLE;
			default:
				state_d = ST_IDLE;
		endcase
	end

	// State, step position, bank and frame levels
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state_q    <= ST_IDLE;
			step_idx_q <= '0;
			addr_q     <= ADDR_BASE;
			bank_q     <= 1'b0;		// Bank A first
			frame_q    <= 1'b0;
			en_fe_q    <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			case (state_q)
				ST_IDLE:
				begin
					step_idx_q <= '0;
					addr_q     <= ADDR_BASE;
				end
				ST_ACCESS:
					if (pready_i)
					begin
						frame_q <= 1'b1;	// High together with start_op
						en_fe_q <= 1'b1;
					end
				ST_FIRE:
					bank_q <= ~bank_q;	// Alternates across frames too
				ST_END_WAIT:
					if (step_done && !last_step)
					begin
						step_idx_q <= step_idx_q + 1'b1;
						addr_q     <= addr_q + 1'b1;
					end
				ST_LAST_READ:
					en_fe_q <= 1'b0;
				ST_END_READ:
					if (end_read_i)
						frame_q <= 1'b0;
				default:
				begin
				end
			endcase
		end
	end

	// Interrupt flag and timeout counter of the running step
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			irq_seen_q <= 1'b0;
			tmo_cnt_q  <= '0;
		end
		else if (state_q == ST_FIRE)
		begin
			irq_seen_q <= 1'b0;
			tmo_cnt_q  <= '0;
		end
		else if (in_step)
		begin
			if (irq_fall)
				irq_seen_q <= 1'b1;
			if (tmo_cnt_q != '1)	// Saturating
				tmo_cnt_q <= tmo_cnt_q + 1'b1;
		end
	end

	// Step word taken in the cycle with pready
	always_ff @(posedge clk)
	begin
		if (state_q == ST_ACCESS && pready_i)
		begin
			word_q.timeout <= prdata_i[cemf_pkg::TIMEOUT_LSB +: cemf_pkg::TIMEOUT_W];
			word_q.delay   <= prdata_i[cemf_pkg::DELAY_LSB +: cemf_pkg::DELAY_W];
			word_q.cycles  <= prdata_i[cemf_pkg::CYCLES_LSB +: cemf_pkg::CYCLES_W];
		end
	end

	// APB read
	assign psel_o    = state_q inside {ST_SETUP, ST_ACCESS};
	assign penable_o = state_q == ST_ACCESS;
	assign paddr_o   = addr_q;	// Held through wait states

	// Bank strobes, download of the other bank from the second step on
	assign start_op_a_o   = (state_q == ST_FIRE) && !bank_q;
	assign start_op_b_o   = (state_q == ST_FIRE) && bank_q;
	assign start_read_a_o = bank_q
		&& (((state_q == ST_FIRE) && !first_step) || (state_q == ST_LAST_READ));
	assign start_read_b_o = !bank_q
		&& (((state_q == ST_FIRE) && !first_step) || (state_q == ST_LAST_READ));

	assign start_gen_o   = state_q == ST_START_GEN;
	assign stop_gen_o    = state_q == ST_STOP_GEN;
	assign cemf_cnt_en_o = in_step;	// From the cycle after start_op
	assign step_active_o = (state_q inside {ST_SETUP, ST_ACCESS, ST_FIRE})
		|| (in_step && !irq_seen_q);
	assign frame_o       = frame_q;
	assign en_fe_o       = en_fe_q;
	assign stop_o        = (state_q == ST_IDLE) && !run_i;

endmodule

/* source/tdc_event_sync.sv */
module tdc_event_sync #(
	parameter int unsigned SYNC_STAGES = 2	// Synchronizer depth, 2 or more
) (
	input  logic clk,
	input  logic rst_n,
	input  logic trigger_i,		// Raw TDC trigger
	input  logic intb_a_i,		// Raw interrupt of bank A, active low
	input  logic intb_b_i,		// Raw interrupt of bank B, active low
	output logic trigger_o,		// Synchronized trigger level
	output logic intb_a_fall_o,	// Interrupt A asserted
	output logic intb_b_fall_o	// Interrupt B asserted
);

	// Lane order in each stage: {trigger, intb_a, intb_b}
	logic [SYNC_STAGES-1:0][2:0] sync_q;
	logic [1:0]                  int_hist_q;	// Previous interrupt levels {a, b}
	logic [1:0]                  int_fall_q;	// Registered fall flags {a, b}
	logic [2:0]                  sync_last;		// Output of the last stage

	assign sync_last = sync_q[SYNC_STAGES-1];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			// Interrupts idle high, so no fall is seen after reset
			sync_q     <= {SYNC_STAGES{3'b011}};
			int_hist_q <= 2'b11;
			int_fall_q <= 2'b00;
		end
		else
		begin
			sync_q     <= {sync_q[SYNC_STAGES-2:0], {trigger_i, intb_a_i, intb_b_i}};
			int_hist_q <= sync_last[1:0];
			int_fall_q <= int_hist_q & ~sync_last[1:0];	// High before, low now
		end
	end

	assign trigger_o     = sync_last[2];	// Level, no edge detect
	assign intb_a_fall_o = int_fall_q[1];
	assign intb_b_fall_o = int_fall_q[0];

endmodule

/* source/cemf_edge_counter.sv */
module cemf_edge_counter #(
	parameter int unsigned SYNC_STAGES = 2	// Synchronizer depth, 2 or more
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            cemf_i,		// Raw CEMF square wave
	input  logic                            cnt_en_i,	// Count enable, clears count when low
	output logic                            rise_o,		// One cycle per rising edge
	output logic                            fall_o,		// One cycle per falling edge
	output logic [cemf_pkg::CEMF_CNT_W-1:0] count_o		// Rising edges since enable
);

	logic [SYNC_STAGES-1:0] sync_q;	// Synchronizer chain, bit 0 first
	logic                   hist_q;	// Previous synchronized level
	logic                   rise_q;
	logic                   fall_q;
	logic [cemf_pkg::CEMF_CNT_W-1:0] count_q;

	// Synchronizer, history flop and registered edge flags
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sync_q <= '0;
			hist_q <= 1'b0;
			rise_q <= 1'b0;
			fall_q <= 1'b0;
		end
		else
		begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], cemf_i};
			hist_q <= sync_q[SYNC_STAGES-1];
			rise_q <= sync_q[SYNC_STAGES-1] & ~hist_q;	// Low to high
			fall_q <= ~sync_q[SYNC_STAGES-1] & hist_q;	// High to low
		end
	end

	// Count flagged rises while enabled
	// A flagged rise shows up in the count one cycle later
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			count_q <= '0;
		else if (!cnt_en_i)
			count_q <= '0;
		else if (rise_q && count_q != '1)	// Saturate at full scale
			count_q <= count_q + 1'b1;
	end

	assign rise_o  = rise_q;
	assign fall_o  = fall_q;
	assign count_o = count_q;

endmodule

/* source/cemf_pkg.sv */
package cemf_pkg;

	// APB read bus
	localparam int unsigned ADDR_W = 16;	// Step word address width
	localparam int unsigned DATA_W = 32;	// Read data width

	// Step count and step index width
	localparam int unsigned STEP_W = 7;

	// CEMF rising edge counter
	localparam int unsigned CEMF_CNT_W = 16;

	// Field widths of the step word
	localparam int unsigned CYCLES_W  = 8;	// Window length in CEMF cycles
	localparam int unsigned DELAY_W   = 8;	// Delay before start in CEMF cycles
	localparam int unsigned TIMEOUT_W = 16;	// Step timeout in clocks

	// Field positions in the step word
	localparam int unsigned CYCLES_LSB  = 0;	// Bits 7..0
	localparam int unsigned DELAY_LSB   = 8;	// Bits 15..8
	localparam int unsigned TIMEOUT_LSB = 16;	// Bits 31..16

	// One step word as stored in memory, MSB first
	typedef struct packed {
		logic [TIMEOUT_W-1:0] timeout;	// Clocks from start_op until the step may end
		logic [DELAY_W-1:0]   delay;	// CEMF cycles before start_gen
		logic [CYCLES_W-1:0]  cycles;	// CEMF cycles between start_gen and stop_gen
	} step_word_t;

	// The three fields fill the data word exactly
	localparam int unsigned STEP_WORD_W = $bits(step_word_t);

endpackage
